// ==== Bender.yml ====
package:
  name: circle_op_handler

sources:
  - src/position_pkg.sv
  - src/quadrant_finder.sv
  - src/num_steps_calculator.sv
  - src/circle_step_walker.sv
  - src/circle_op_ctrl.sv
  - src/circle_op_handler.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/circle_op_handler_tb.sv

// ==== flist.f ====
src/position_pkg.sv
src/quadrant_finder.sv
src/num_steps_calculator.sv
src/circle_step_walker.sv
src/circle_op_ctrl.sv
src/circle_op_handler.sv
sim/tb_clock_gen.sv
sim/circle_op_handler_tb.sv

// ==== sim/circle_op_handler_tb.sv ====
`timescale 1ns/1ns

module circle_op_handler_tb;

	localparam int NUM_TESTS   = 24;
	localparam int MAX_R       = 40;
	localparam int MAX_HOLD    = 40;
	localparam int MOVE_CYCLES = 8 * MAX_R + 3 + MAX_HOLD; // longest move from start to done
	localparam int WATCHDOG_NS = NUM_TESTS * (MOVE_CYCLES + 10) * 20 + 2000;

	logic                  clk;
	logic                  arst_n;
	logic                  start;
	logic                  hold;
	logic                  is_cw;
	position_pkg::coord_t  start_x;
	position_pkg::coord_t  start_y;
	position_pkg::coord_t  end_x;
	position_pkg::coord_t  end_y;
	position_pkg::radius_t r;
	logic                  step_x;
	logic                  step_y;
	logic                  dir_x;
	logic                  dir_y;
	position_pkg::coord_t  pos_x;
	position_pkg::coord_t  pos_y;
	position_pkg::steps_t  num_steps;
	logic                  busy;
	logic                  done;

	logic [31:0] lcg_state = 32'd74141;
	int          errors = 0;
	int          failed_moves = 0;

	tb_clock_gen clock_gen (.clk(clk));

	circle_op_handler uut (.*);

	function automatic int next_random(int range);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]) % range;
	endfunction

	function automatic int abs_int(int v);
		return (v < 0) ? -v : v;
	endfunction

	// the origin counts as quadrant 1 and other axis points lead into the next quadrant
	function automatic int quadrant_of(int x, int y);
		if ((x > 0 && y >= 0) || (x == 0 && y == 0)) return 1;
		if (x <= 0 && y > 0) return 2;
		if (x < 0 && y <= 0) return 3;
		return 4;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
			errors++;
		end
	endtask

	// one step of the lattice walk where the x step wins a tie
	task automatic walk_step(inout int x, inout int y, input int rad, input bit cw,
		output bit on_x, output bit up);
		int dx;
		int dy;
		case (quadrant_of(x, y))
			1: begin
				dx = -1;
				dy = 1;
			end
			2: begin
				dx = -1;
				dy = -1;
			end
			3: begin
				dx = 1;
				dy = -1;
			end
			default: begin
				dx = 1;
				dy = 1;
			end
		endcase
		if (cw) begin
			dx = -dx;
			dy = -dy;
		end
		on_x = abs_int((x + dx) * (x + dx) + y * y - rad * rad) <=
		       abs_int(x * x + (y + dy) * (y + dy) - rad * rad);
		up = on_x ? (dx > 0) : (dy > 0);
		if (on_x) x += dx;
		else y += dy;
	endtask

	// endpoints are taken k steps along the walk from (rad, 0) in the move's own sense
	task automatic point_on_path(input int rad, input bit cw, input int k,
		output int px, output int py);
		bit on_x;
		bit up;
		px = rad;
		py = 0;
		repeat (k) walk_step(px, py, rad, cw, on_x, up);
	endtask

	function automatic int arc_steps(int sx, int sy, int ex, int ey, int rad, bit cw);
		int  qs;
		int  qe;
		int  ccw;
		bit  ahead;
		qs = quadrant_of(sx, sy);
		qe = quadrant_of(ex, ey);
		if (qs == 1 || qs == 3) ahead = abs_int(ex) < abs_int(sx) && abs_int(ey) > abs_int(sy);
		else ahead = abs_int(ex) > abs_int(sx) && abs_int(ey) < abs_int(sy);
		if (qs == qe && ahead) begin
			ccw = abs_int(ex - sx) + abs_int(ey - sy);
		end else begin
			ccw = 2 * rad * ((qe - qs + 3) % 4); // quadrants passed fully
			ccw += (qs == 1 || qs == 3) ? abs_int(sx) - abs_int(sy) + rad
			                            : rad - abs_int(sx) + abs_int(sy);
			ccw += (qe == 1 || qe == 3) ? rad - abs_int(ex) + abs_int(ey)
			                            : abs_int(ex) - abs_int(ey) + rad;
		end
		if (cw && !(sx == ex && sy == ey)) return 8 * rad - ccw;
		return ccw;
	endfunction

	task automatic run_move(input int idx);
		int rad;
		bit cw;
		int sx;
		int sy;
		int ex;
		int ey;
		int mx;
		int my;
		int exp_n;
		int seen = 0;
		int held_total = 0;
		int cyc = 0;
		int zero_cyc = -1;
		bit on_x;
		bit up;
		bit got_done = 0;
		int errors_before;
		errors_before = errors;
		rad = 4 + next_random(MAX_R - 3);
		cw = (next_random(2) == 1);
		point_on_path(rad, cw, next_random(8 * rad), sx, sy);
		if (idx % 6 == 5) begin
			ex = sx; // a closed arc is a full circle
			ey = sy;
		end else begin
			point_on_path(rad, cw, next_random(8 * rad), ex, ey);
		end
		exp_n = arc_steps(sx, sy, ex, ey, rad, cw);
		mx = sx;
		my = sy;
		@(posedge clk);
		#2;
		start = 1'b1;
		is_cw = cw;
		start_x = position_pkg::coord_t'(sx);
		start_y = position_pkg::coord_t'(sy);
		end_x = position_pkg::coord_t'(ex);
		end_y = position_pkg::coord_t'(ey);
		r = position_pkg::radius_t'(rad);
		while (!got_done && cyc <= MOVE_CYCLES) begin
			@(negedge clk);
			if (cyc >= 2 && seen == exp_n && zero_cyc < 0) zero_cyc = cyc;
			check_value("busy", busy, cyc >= 1);
			check_value("done", done, zero_cyc >= 0 && cyc == zero_cyc + 1);
			check_value("step_x & step_y", step_x & step_y, 0);
			check_value("step_x | step_y", step_x | step_y, cyc >= 2 && !hold && seen < exp_n);
			if (cyc == 2) check_value("num_steps", num_steps, exp_n);
			if (step_x | step_y) begin
				check_value("pos_x", pos_x, position_pkg::coord_t'(mx));
				check_value("pos_y", pos_y, position_pkg::coord_t'(my));
				walk_step(mx, my, rad, cw, on_x, up);
				check_value("step_x", step_x, on_x);
				check_value(on_x ? "dir_x" : "dir_y", on_x ? dir_x : dir_y, up);
				seen++;
			end
			got_done = done;
			@(posedge clk);
			#2;
			cyc++;
			start = (idx % 4 == 3) && (cyc == 1); // a second command that must be ignored
			if (start) begin
				is_cw = ~cw;
				start_x = position_pkg::coord_t'(next_random(256));
				end_y = position_pkg::coord_t'(next_random(256));
				r = position_pkg::radius_t'(next_random(64));
			end
			hold = !got_done && (idx % 3 == 1) && cyc >= 2 && held_total < MAX_HOLD &&
			       next_random(3) == 0;
			held_total += hold;
		end
		if (!got_done) begin
			$display("move %0d never gave a done pulse within %0d cycles", idx, MOVE_CYCLES);
			errors++;
		end
		repeat (3) begin
			@(negedge clk);
			check_value("busy after done", busy, 0);
			check_value("done after done", done, 0);
			check_value("step after done", step_x | step_y, 0);
		end
		check_value("step pulse count", seen, exp_n);
		check_value("final pos_x", pos_x, position_pkg::coord_t'(ex));
		check_value("final pos_y", pos_y, position_pkg::coord_t'(ey));
		if (errors != errors_before) failed_moves++;
		$display("move %0d: r=%0d %s (%0d,%0d) to (%0d,%0d), %0d steps, %0d held, %0d errors",
			idx, rad, cw ? "cw" : "ccw", sx, sy, ex, ey, exp_n, held_total,
			errors - errors_before);
	endtask

	initial begin
		arst_n = 1'b0;
		start = 1'b0;
		hold = 1'b0;
		is_cw = 1'b0;
		start_x = '0;
		start_y = '0;
		end_x = '0;
		end_y = '0;
		r = '0;
		repeat (16) @(posedge clk);
		#2;
		arst_n = 1'b1;
		repeat (5) begin
			@(negedge clk);
			check_value("busy", busy, 0);
			check_value("done", done, 0);
			check_value("step_x | step_y", step_x | step_y, 0);
			check_value("pos_x", pos_x, 0);
			check_value("pos_y", pos_y, 0);
			check_value("num_steps", num_steps, 0);
		end
		$display("idle after reset: %0d errors", errors);
		for (int i = 0; i < NUM_TESTS; i++) begin
			run_move(i);
		end
		$display("%0d moves run, %0d moves failed, %0d errors", NUM_TESTS, failed_moves, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all moves finished");
		$display("Something failed");
		$finish;
	end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk
);

	localparam int HALF_PERIOD = 10; // 20 ns period

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

// ==== src/circle_op_ctrl.sv ====
`timescale 1ns/1ns

module circle_op_ctrl (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  start,
	input  logic                  hold,
	input  logic                  is_cw,
	input  position_pkg::coord_t  start_x,
	input  position_pkg::coord_t  start_y,
	input  position_pkg::coord_t  end_x,
	input  position_pkg::coord_t  end_y,
	input  position_pkg::radius_t r,
	input  position_pkg::steps_t  calc_steps,
	output logic                  cmd_is_cw,
	output position_pkg::coord_t  cmd_start_x,
	output position_pkg::coord_t  cmd_start_y,
	output position_pkg::coord_t  cmd_end_x,
	output position_pkg::coord_t  cmd_end_y,
	output position_pkg::radius_t cmd_r,
	output position_pkg::steps_t  num_steps,
	output logic                  load,
	output logic                  advance,
	output logic                  busy,
	output logic                  done
);

	position_pkg::op_state_t state;
	position_pkg::steps_t    remaining; // steps still to take in this move

	assign busy    = (state != position_pkg::op_idle);
	assign done    = (state == position_pkg::op_finish);
	assign load    = (state == position_pkg::op_calc); // walker jumps to the start point
	assign advance = (state == position_pkg::op_run) && !hold && (remaining != '0);

	// command fields only change when a new move is accepted
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd_is_cw   <= 1'b0;
			cmd_start_x <= '0;
			cmd_start_y <= '0;
			cmd_end_x   <= '0;
			cmd_end_y   <= '0;
			cmd_r       <= '0;
		end else if (start && !busy) begin
			cmd_is_cw   <= is_cw;
			cmd_start_x <= start_x;
			cmd_start_y <= start_y;
			cmd_end_x   <= end_x;
			cmd_end_y   <= end_y;
			cmd_r       <= r;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= position_pkg::op_idle;
			num_steps <= '0;
			remaining <= '0;
		end else begin
			case (state)
				position_pkg::op_idle: if (start) state <= position_pkg::op_calc;
				position_pkg::op_calc: begin
					num_steps <= calc_steps;
					remaining <= calc_steps;
					state     <= position_pkg::op_run;
				end
				position_pkg::op_run: begin
					if (remaining == '0) state <= position_pkg::op_finish;
					else if (advance) remaining <= remaining - 1'b1;
				end
				default: state <= position_pkg::op_idle; // finish lasts one cycle
			endcase
		end
	end

endmodule

// ==== src/circle_op_handler.sv ====
`timescale 1ns/1ns

module circle_op_handler (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  start,
	input  logic                  hold,
	input  logic                  is_cw,
	input  position_pkg::coord_t  start_x,
	input  position_pkg::coord_t  start_y,
	input  position_pkg::coord_t  end_x,
	input  position_pkg::coord_t  end_y,
	input  position_pkg::radius_t r,
	output logic                  step_x,
	output logic                  step_y,
	output logic                  dir_x,
	output logic                  dir_y,
	output position_pkg::coord_t  pos_x,
	output position_pkg::coord_t  pos_y,
	output position_pkg::steps_t  num_steps,
	output logic                  busy,
	output logic                  done
);

	logic                  cmd_is_cw;
	position_pkg::coord_t  cmd_start_x;
	position_pkg::coord_t  cmd_start_y;
	position_pkg::coord_t  cmd_end_x;
	position_pkg::coord_t  cmd_end_y;
	position_pkg::radius_t cmd_r;
	position_pkg::steps_t  calc_steps;
	logic                  load;
	logic                  advance;

	circle_op_ctrl ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.hold       (hold),
		.is_cw      (is_cw),
		.start_x    (start_x),
		.start_y    (start_y),
		.end_x      (end_x),
		.end_y      (end_y),
		.r          (r),
		.calc_steps (calc_steps),
		.cmd_is_cw  (cmd_is_cw),
		.cmd_start_x(cmd_start_x),
		.cmd_start_y(cmd_start_y),
		.cmd_end_x  (cmd_end_x),
		.cmd_end_y  (cmd_end_y),
		.cmd_r      (cmd_r),
		.num_steps  (num_steps),
		.load       (load),
		.advance    (advance),
		.busy       (busy),
		.done       (done)
	);

	// works on the latched command so the count is stable through calc
	num_steps_calculator steps_calc (
		.is_cw    (cmd_is_cw),
		.start_x  (cmd_start_x),
		.start_y  (cmd_start_y),
		.end_x    (cmd_end_x),
		.end_y    (cmd_end_y),
		.r        (cmd_r),
		.num_steps(calc_steps)
	);

	circle_step_walker walker (
		.clk    (clk),
		.arst_n (arst_n),
		.load   (load),
		.advance(advance),
		.is_cw  (cmd_is_cw),
		.start_x(cmd_start_x),
		.start_y(cmd_start_y),
		.r      (cmd_r),
		.pos_x  (pos_x),
		.pos_y  (pos_y),
		.step_x (step_x),
		.step_y (step_y),
		.dir_x  (dir_x),
		.dir_y  (dir_y)
	);

endmodule

// ==== src/circle_step_walker.sv ====
`timescale 1ns/1ns

module circle_step_walker (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  load,
	input  logic                  advance,
	input  logic                  is_cw,
	input  position_pkg::coord_t  start_x,
	input  position_pkg::coord_t  start_y,
	input  position_pkg::radius_t r,
	output position_pkg::coord_t  pos_x,
	output position_pkg::coord_t  pos_y,
	output logic                  step_x,
	output logic                  step_y,
	output logic                  dir_x,
	output logic                  dir_y
);

	position_pkg::pos_quadrant_t quadrant;

	logic signed [position_pkg::NUM_BITS:0] cur_x; // one bit wider so a step cannot overflow
	logic signed [position_pkg::NUM_BITS:0] cur_y;
	logic signed [position_pkg::NUM_BITS:0] cand_x;
	logic signed [position_pkg::NUM_BITS:0] cand_y;

	logic [2*position_pkg::NUM_BITS+2:0] err_x;
	logic [2*position_pkg::NUM_BITS+2:0] err_y;
	logic                                take_x;

	// distance of a lattice point's squared radius from r squared
	function automatic logic [2*position_pkg::NUM_BITS+2:0] radius_error(
		input logic signed [position_pkg::NUM_BITS:0] a,
		input logic signed [position_pkg::NUM_BITS:0] b,
		input position_pkg::radius_t                  rad
	);
		logic signed [2*position_pkg::NUM_BITS+2:0] diff;
		logic signed [position_pkg::NUM_BITS:0]     rad_s;
		rad_s = $signed({1'b0, rad});
		diff  = a * a + b * b - rad_s * rad_s;
		return (diff < 0) ? -diff : diff;
	endfunction

	quadrant_finder find_quadrant (
		.relative_x(pos_x),
		.relative_y(pos_y),
		.quadrant  (quadrant)
	);

	// when turning counter-clockwise x grows below the x axis and y grows right of the y axis
	assign dir_x = is_cw ^ ((quadrant == position_pkg::pos_quadrant_3) ||
	                        (quadrant == position_pkg::pos_quadrant_4));
	assign dir_y = is_cw ^ ((quadrant == position_pkg::pos_quadrant_1) ||
	                        (quadrant == position_pkg::pos_quadrant_4));

	assign cur_x  = $signed({pos_x[position_pkg::NUM_BITS-1], pos_x});
	assign cur_y  = $signed({pos_y[position_pkg::NUM_BITS-1], pos_y});
	assign cand_x = dir_x ? cur_x + 1 : cur_x - 1;
	assign cand_y = dir_y ? cur_y + 1 : cur_y - 1;

	assign err_x  = radius_error(cand_x, cur_y, r);
	assign err_y  = radius_error(cur_x, cand_y, r);
	assign take_x = (err_x <= err_y); // ties go to the x step

	assign step_x = advance && take_x;
	assign step_y = advance && !take_x;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pos_x <= '0;
			pos_y <= '0;
		end else if (load) begin
			pos_x <= start_x;
			pos_y <= start_y;
		end else if (advance) begin
			if (take_x) begin
				pos_x <= cand_x[position_pkg::NUM_BITS-1:0];
			end else begin
				pos_y <= cand_y[position_pkg::NUM_BITS-1:0];
			end
		end
	end

endmodule

// ==== src/num_steps_calculator.sv ====
`timescale 1ns/1ns

module num_steps_calculator (
	input  logic                   is_cw,
	input  position_pkg::coord_t   start_x,
	input  position_pkg::coord_t   start_y,
	input  position_pkg::coord_t   end_x,
	input  position_pkg::coord_t   end_y,
	input  position_pkg::radius_t  r,
	output position_pkg::steps_t   num_steps
);

	position_pkg::pos_quadrant_t start_quadrant;
	position_pkg::pos_quadrant_t end_quadrant;

	position_pkg::radius_t abs_start_x;
	position_pkg::radius_t abs_start_y;
	position_pkg::radius_t abs_end_x;
	position_pkg::radius_t abs_end_y;
	position_pkg::steps_t  r_ext;

	position_pkg::steps_t abs_dx;
	position_pkg::steps_t abs_dy;
	position_pkg::steps_t full_steps;
	position_pkg::steps_t start_to_axis_steps;
	position_pkg::steps_t axis_to_end_steps;
	position_pkg::steps_t steps_ccw;

	logic [1:0] quad_passed; // quadrants crossed from axis to axis
	logic       start_odd;   // start lies in quadrant 1 or 3
	logic       end_odd;
	logic       crossing;
	logic       same_point;

	quadrant_finder find_start_quadrant (
		.relative_x(start_x),
		.relative_y(start_y),
		.quadrant  (start_quadrant)
	);

	quadrant_finder find_end_quadrant (
		.relative_x(end_x),
		.relative_y(end_y),
		.quadrant  (end_quadrant)
	);

	// magnitudes fit in NUM_BITS-1 bits since the radius stays below 64
	assign abs_start_x = start_x[position_pkg::NUM_BITS-1] ? -start_x : start_x;
	assign abs_start_y = start_y[position_pkg::NUM_BITS-1] ? -start_y : start_y;
	assign abs_end_x   = end_x[position_pkg::NUM_BITS-1] ? -end_x : end_x;
	assign abs_end_y   = end_y[position_pkg::NUM_BITS-1] ? -end_y : end_y;
	assign r_ext       = position_pkg::steps_t'(r);

	// inside one quadrant both coordinates keep their sign, so magnitudes are enough
	assign abs_dx = (abs_end_x >= abs_start_x) ? abs_end_x - abs_start_x : abs_start_x - abs_end_x;
	assign abs_dy = (abs_end_y >= abs_start_y) ? abs_end_y - abs_start_y : abs_start_y - abs_end_y;

	assign start_odd = (start_quadrant == position_pkg::pos_quadrant_1) ||
	                   (start_quadrant == position_pkg::pos_quadrant_3);
	assign end_odd   = (end_quadrant == position_pkg::pos_quadrant_1) ||
	                   (end_quadrant == position_pkg::pos_quadrant_3);

	assign same_point = (start_x == end_x) && (start_y == end_y);

	// the end must be strictly ahead of the start to stay inside the quadrant
	always_comb begin
		if (start_quadrant != end_quadrant) begin
			crossing = 1'b1;
		end else if (start_odd) begin
			crossing = (abs_end_x >= abs_start_x) || (abs_end_y <= abs_start_y);
		end else begin
			crossing = (abs_end_x <= abs_start_x) || (abs_end_y >= abs_start_y);
		end
	end

	// wraps to three when start and end share a quadrant and the arc goes all the way round
	assign quad_passed = 2'(end_quadrant) - 2'(start_quadrant) - 2'd1;
	assign full_steps  = position_pkg::steps_t'(quad_passed) * (r_ext << 1);

	always_comb begin
		if (start_odd) begin
			start_to_axis_steps = abs_start_x - abs_start_y + r_ext;
		end else begin
			start_to_axis_steps = r_ext - abs_start_x + abs_start_y;
		end

		if (end_odd) begin
			axis_to_end_steps = r_ext - abs_end_x + abs_end_y;
		end else begin
			axis_to_end_steps = abs_end_x - abs_end_y + r_ext;
		end
	end

	assign steps_ccw = crossing ? full_steps + start_to_axis_steps + axis_to_end_steps
	                            : abs_dx + abs_dy;

	// a closed arc is a full circle in either sense
	always_comb begin
		if (!is_cw || same_point) begin
			num_steps = steps_ccw;
		end else begin
			num_steps = (r_ext << 3) - steps_ccw;
		end
	end

endmodule

// ==== src/position_pkg.sv ====
package position_pkg;

	// coordinates are signed and relative to the circle centre
	localparam int NUM_BITS = 8;

	// a full circle takes at most eight times the radius in unit steps
	localparam int STEP_BITS = NUM_BITS + 3;

	typedef logic [NUM_BITS-1:0] coord_t;  // signed, two's complement
	typedef logic [NUM_BITS-1:0] radius_t; // unsigned, kept below 64
	typedef logic [STEP_BITS-1:0] steps_t;

	// axis points belong to the quadrant they lead into when turning counter-clockwise
	typedef enum logic [1:0] {
		pos_quadrant_1 = 2'd0,
		pos_quadrant_2 = 2'd1,
		pos_quadrant_3 = 2'd2,
		pos_quadrant_4 = 2'd3
	} pos_quadrant_t;

	typedef enum logic [1:0] {
		op_idle   = 2'd0,
		op_calc   = 2'd1,
		op_run    = 2'd2,
		op_finish = 2'd3
	} op_state_t;

endpackage

// ==== src/quadrant_finder.sv ====
`timescale 1ns/1ns

module quadrant_finder (
	input  position_pkg::coord_t        relative_x,
	input  position_pkg::coord_t        relative_y,
	output position_pkg::pos_quadrant_t quadrant
);

	logic x_neg;
	logic y_neg;
	logic x_zero;
	logic y_zero;

	assign x_neg  = relative_x[position_pkg::NUM_BITS-1];
	assign y_neg  = relative_y[position_pkg::NUM_BITS-1];
	assign x_zero = (relative_x == '0);
	assign y_zero = (relative_y == '0);

	always_comb begin
		if (y_neg && !x_neg) begin
			quadrant = position_pkg::pos_quadrant_4; // x >= 0, y < 0
		end else if (x_neg && (y_neg || y_zero)) begin
			quadrant = position_pkg::pos_quadrant_3; // x < 0, y <= 0
		end else if ((x_neg || x_zero) && !y_zero) begin
			quadrant = position_pkg::pos_quadrant_2; // x <= 0, y > 0
		end else begin
			quadrant = position_pkg::pos_quadrant_1; // x > 0 with y >= 0, and the origin
		end
	end

endmodule
